// File: list.f
+incdir+logic
logic/mips_pkg.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/stage_reg.sv
logic/execute_stage.sv
logic/mips_core.sv
verif/mips_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the mips_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module mips_core_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/Vmips_core_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
        echo "simulation exited with status $sim_status"
fi

if grep -q "^TEST PASSED$" "$LOG"; then
        exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: verif/mips_core_tb.sv
// mips_core testbench with clock, reset, rom model, program builder, reference model and checks
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_core_tb;

        localparam int PROG_MAX = 256;
        localparam int RANDOM_COUNT = 200;
        localparam int WATCHDOG_MARGIN = 50;

        logic            clk;
        logic            rst_n_i;
        mips_pkg::word_t rom_data_i_le;
        mips_pkg::word_t rom_addr_o;
        logic            rom_ce_o;
        mips_pkg::word_t ram_addr_o;
        mips_pkg::word_t ram_data_o;
        logic            ram_we_o;

        mips_pkg::word_t prog_mem [PROG_MAX];
        mips_pkg::word_t prog_len = '0;
        mips_pkg::word_t rom_word_idx;
        mips_pkg::word_t lcg_state;
        mips_pkg::word_t exp_fetch = `MIPS_RESET_PC;
        mips_pkg::word_t exp_addr_q [$];
        mips_pkg::word_t exp_data_q [$];
        int              exp_count;
        int              stores_seen = 0;
        logic            program_ready = 1'b0;

        mips_core mips_core_inst (
                .clk          (clk),
                .rst_n_i      (rst_n_i),
                .rom_data_i_le(rom_data_i_le),
                .rom_addr_o   (rom_addr_o),
                .rom_ce_o     (rom_ce_o),
                .ram_addr_o   (ram_addr_o),
                .ram_data_o   (ram_data_o),
                .ram_we_o     (ram_we_o)
        );

        always #5 clk = ~clk;

        function automatic mips_pkg::word_t swap_bytes(input mips_pkg::word_t w);
                return {w[7:0], w[15:8], w[23:16], w[31:24]};
        endfunction

        // rom answers in the same cycle, little-endian, zero past the end
        always_comb begin
                rom_word_idx = {2'b00, rom_addr_o[31:2]};
                if (rom_word_idx < prog_len) begin
                        rom_data_i_le = swap_bytes(prog_mem[rom_word_idx[7:0]]);
                end else begin
                        rom_data_i_le = '0;
                end
        end

        function automatic mips_pkg::word_t encode_rtype(input logic [5:0] funct,
                input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
                return {6'b000000, rs, rt, rd, 5'b00000, funct};
        endfunction

        function automatic mips_pkg::word_t encode_itype(input logic [5:0] opcode,
                input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
                return {opcode, rs, rt, imm};
        endfunction

        function automatic mips_pkg::word_t next_rand();
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return lcg_state;
        endfunction

        // a quarter of the random mix are stores
        function automatic mips_pkg::word_t random_inst();
                mips_pkg::word_t sel;
                mips_pkg::word_t fields;
                mips_pkg::word_t imm_r;
                logic [4:0]      rs_f;
                logic [4:0]      rt_f;
                logic [4:0]      rd_f;
                sel = next_rand();
                fields = next_rand();
                imm_r = next_rand();
                rs_f = fields[31:27];
                rt_f = fields[26:22];
                rd_f = fields[21:17];
                case (sel[31:28])
                        4'd0: return encode_rtype(mips_pkg::FN_ADDU, rs_f, rt_f, rd_f);
                        4'd1: return encode_rtype(mips_pkg::FN_SUBU, rs_f, rt_f, rd_f);
                        4'd2: return encode_rtype(mips_pkg::FN_AND, rs_f, rt_f, rd_f);
                        4'd3: return encode_rtype(mips_pkg::FN_OR, rs_f, rt_f, rd_f);
                        4'd4: return encode_rtype(mips_pkg::FN_XOR, rs_f, rt_f, rd_f);
                        4'd5: return encode_rtype(mips_pkg::FN_NOR, rs_f, rt_f, rd_f);
                        4'd6: return encode_rtype(mips_pkg::FN_SLT, rs_f, rt_f, rd_f);
                        4'd7: return encode_itype(mips_pkg::OPC_ADDIU, rs_f, rt_f, imm_r[31:16]);
                        4'd8: return encode_itype(mips_pkg::OPC_ANDI, rs_f, rt_f, imm_r[31:16]);
                        4'd9: return encode_itype(mips_pkg::OPC_ORI, rs_f, rt_f, imm_r[31:16]);
                        4'd10: return encode_itype(mips_pkg::OPC_XORI, rs_f, rt_f, imm_r[31:16]);
                        4'd11: return encode_itype(mips_pkg::OPC_LUI, rs_f, rt_f, imm_r[31:16]);
                        default: return encode_itype(mips_pkg::OPC_SW, rs_f, rt_f, imm_r[31:16]);
                endcase
        endfunction

        task automatic append_inst(input mips_pkg::word_t w);
                prog_mem[prog_len[7:0]] = w;
                prog_len = prog_len + 1;
        endtask

        // result of inst lands in dst, then goes out through a store at base r2
        task automatic append_with_store(input mips_pkg::word_t inst, input logic [4:0] dst,
                input logic [15:0] off);
                append_inst(inst);
                append_inst(encode_itype(mips_pkg::OPC_SW, 5'd2, dst, off));
        endtask

        task automatic build_program();
                lcg_state = 32'h120a_2305;
                // known word, base address, positive and negative offsets
                append_inst(encode_itype(mips_pkg::OPC_LUI, 0, 1, 16'h1234));
                append_inst(encode_itype(mips_pkg::OPC_ORI, 1, 1, 16'h5678));
                append_inst(encode_itype(mips_pkg::OPC_ORI, 0, 2, 16'h0100));
                append_inst(encode_itype(mips_pkg::OPC_SW, 2, 1, 16'h0008));
                append_inst(encode_itype(mips_pkg::OPC_SW, 2, 1, 16'hfffc));
                // dependent pairs at distance 1, 2 and 3
                append_inst(encode_itype(mips_pkg::OPC_ADDIU, 0, 3, 16'h0005));
                append_inst(encode_itype(mips_pkg::OPC_SW, 2, 3, 16'h0010));
                append_inst(encode_itype(mips_pkg::OPC_ADDIU, 0, 4, 16'h0007));
                append_inst(32'h0000_0000);
                append_inst(encode_itype(mips_pkg::OPC_SW, 2, 4, 16'h0014));
                append_inst(encode_itype(mips_pkg::OPC_ADDIU, 0, 5, 16'h0009));
                append_inst(32'h0000_0000);
                append_inst(32'h0000_0000);
                append_inst(encode_itype(mips_pkg::OPC_SW, 2, 5, 16'h0018));
                append_inst(encode_itype(mips_pkg::OPC_ADDIU, 0, 6, 16'h0200));
                append_inst(encode_itype(mips_pkg::OPC_SW, 6, 1, 16'h0000));
                // execute result must win over the retire result
                append_inst(encode_itype(mips_pkg::OPC_ADDIU, 0, 7, 16'h0001));
                append_inst(encode_itype(mips_pkg::OPC_ADDIU, 7, 7, 16'h0002));
                append_inst(encode_itype(mips_pkg::OPC_SW, 2, 7, 16'h001c));
                // $zero stays zero, unknown encodings change nothing
                append_with_store(encode_itype(mips_pkg::OPC_ADDIU, 0, 0, 16'h0055), 0, 16'h0020);
                append_with_store(encode_rtype(mips_pkg::FN_ADDU, 1, 1, 0), 0, 16'h0024);
                append_inst(encode_itype(6'h3f, 3, 1, 16'hffff));
                append_inst(encode_rtype(6'h3f, 3, 3, 1));
                append_inst(32'h0000_0000);
                append_inst(encode_itype(mips_pkg::OPC_SW, 2, 1, 16'h0028));
                // every alu operation with a negative and a positive operand
                append_inst(encode_itype(mips_pkg::OPC_ADDIU, 0, 8, 16'hfffd));
                append_inst(encode_itype(mips_pkg::OPC_ADDIU, 0, 9, 16'h0006));
                append_with_store(encode_rtype(mips_pkg::FN_ADDU, 8, 9, 20), 20, 16'h0030);
                append_with_store(encode_rtype(mips_pkg::FN_SUBU, 8, 9, 20), 20, 16'h0034);
                append_with_store(encode_rtype(mips_pkg::FN_AND, 8, 9, 20), 20, 16'h0038);
                append_with_store(encode_rtype(mips_pkg::FN_OR, 8, 9, 20), 20, 16'h003c);
                append_with_store(encode_rtype(mips_pkg::FN_XOR, 8, 9, 20), 20, 16'h0040);
                append_with_store(encode_rtype(mips_pkg::FN_NOR, 8, 9, 20), 20, 16'h0044);
                append_with_store(encode_rtype(mips_pkg::FN_SLT, 8, 9, 20), 20, 16'h0048);
                append_with_store(encode_rtype(mips_pkg::FN_SLT, 9, 8, 20), 20, 16'h004c);
                append_with_store(encode_itype(mips_pkg::OPC_ANDI, 8, 20, 16'hf0f0), 20, 16'h0050);
                append_with_store(encode_itype(mips_pkg::OPC_ORI, 9, 20, 16'h8001), 20, 16'h0054);
                append_with_store(encode_itype(mips_pkg::OPC_XORI, 8, 20, 16'h8001), 20, 16'h0058);
                append_with_store(encode_itype(mips_pkg::OPC_ADDIU, 9, 20, 16'hff00), 20, 16'h005c);
                append_with_store(encode_itype(mips_pkg::OPC_LUI, 9, 20, 16'h8765), 20, 16'h0060);
                for (int n = 0; n < RANDOM_COUNT; n++) begin
                        append_inst(random_inst());
                end
        endtask

        // runs the program in order on a model register file, fills the store queues
        function automatic int run_reference();
                mips_pkg::word_t regs [32];
                mips_pkg::word_t inst;
                mips_pkg::word_t a;
                mips_pkg::word_t b;
                mips_pkg::word_t imm_s;
                mips_pkg::word_t imm_z;
                mips_pkg::word_t res;
                logic            wr;
                logic [4:0]      dst;
                for (int r = 0; r < 32; r++) begin
                        regs[r] = '0;
                end
                for (mips_pkg::word_t idx = '0; idx < prog_len; idx++) begin
                        inst = prog_mem[idx[7:0]];
                        a = regs[inst[25:21]];
                        b = regs[inst[20:16]];
                        imm_s = {{16{inst[15]}}, inst[15:0]};
                        imm_z = {16'h0000, inst[15:0]};
                        res = '0;
                        wr = 1'b1;
                        dst = inst[20:16];
                        case (inst[31:26])
                                6'h00: begin
                                        dst = inst[15:11];
                                        case (inst[5:0])
                                                6'h21: res = a + b;
                                                6'h23: res = a - b;
                                                6'h24: res = a & b;
                                                6'h25: res = a | b;
                                                6'h26: res = a ^ b;
                                                6'h27: res = ~(a | b);
                                                6'h2a: res = {31'd0, $signed(a) < $signed(b)};
                                                default: wr = 1'b0;
                                        endcase
                                end
                                6'h09: res = a + imm_s;
                                6'h0c: res = a & imm_z;
                                6'h0d: res = a | imm_z;
                                6'h0e: res = a ^ imm_z;
                                6'h0f: res = {inst[15:0], 16'h0000};
                                6'h2b: begin
                                        wr = 1'b0;
                                        exp_addr_q.push_back(a + imm_s);
                                        exp_data_q.push_back(b);
                                end
                                default: wr = 1'b0;
                        endcase
                        if (wr && (dst != 5'd0)) begin
                                regs[dst] = res;
                        end
                end
                return exp_addr_q.size();
        endfunction

        task automatic report_failure(input string msg);
                $display("%s", msg);
                $display("TEST FAILED");
                $fatal(1, "simulation stopped on the first error");
        endtask

        task automatic check_fetch(input mips_pkg::word_t got, input mips_pkg::word_t expected);
                if (got !== expected) begin
                        report_failure($sformatf("ERROR rom_addr_o got %h expected %h",
                                                 got, expected));
                end
        endtask

        task automatic check_store(input mips_pkg::word_t addr, input mips_pkg::word_t data);
                mips_pkg::word_t want_addr;
                mips_pkg::word_t want_data;
                if (exp_addr_q.size() == 0) begin
                        report_failure($sformatf("an extra store was seen at address %h", addr));
                end else begin
                        want_addr = exp_addr_q.pop_front();
                        want_data = exp_data_q.pop_front();
                        stores_seen++;
                        if (addr !== want_addr) begin
                                report_failure($sformatf("ERROR ram_addr_o got %h expected %h",
                                                         addr, want_addr));
                        end else if (data !== want_data) begin
                                report_failure($sformatf("ERROR ram_data_o got %h expected %h",
                                                         data, want_data));
                        end
                end
        endtask

        always @(posedge clk) begin
                if (!rst_n_i) begin
                        if (rom_ce_o !== 1'b0 || ram_we_o !== 1'b0) begin
                                report_failure("rom_ce_o or ram_we_o was not low during reset");
                        end
                end else begin
                        if (rom_ce_o) begin
                                check_fetch(rom_addr_o, exp_fetch);
                                exp_fetch = exp_fetch + 32'd4;
                        end
                        if (ram_we_o) begin
                                check_store(ram_addr_o, ram_data_o);
                        end
                end
        end

        initial begin
                wait (program_ready);
                #((prog_len + WATCHDOG_MARGIN) * 10);
                report_failure("watchdog expired before the program finished");
        end

        initial begin
                clk = 1'b0;
                rst_n_i = 1'b0;
                build_program();
                exp_count = run_reference();
                program_ready = 1'b1;
                repeat (2) @(posedge clk);
                #1;
                rst_n_i = 1'b1;
                // run until fetch leaves the program, then let the pipeline drain
                while ({2'b00, rom_addr_o[31:2]} < prog_len) begin
                        @(posedge clk);
                        #1;
                end
                repeat (4) @(posedge clk);
                #1;
                if (stores_seen != exp_count) begin
                        report_failure($sformatf("only %0d of %0d expected stores were seen",
                                                 stores_seen, exp_count));
                end else begin
                        $display("TEST PASSED");
                        $finish;
                end
        end

endmodule

// File: logic/mips_core.sv
// core top, fetch, decode, register file, issue and retire registers, execute
`timescale 1ns/1ps

module mips_core (
        input  logic            clk,
        input  logic            rst_n_i,
        input  mips_pkg::word_t rom_data_i_le,
        output mips_pkg::word_t rom_addr_o,
        output logic            rom_ce_o,
        output mips_pkg::word_t ram_addr_o,
        output mips_pkg::word_t ram_data_o,
        output logic            ram_we_o
);

        mips_pkg::word_t     if_inst;
        logic                if_inst_valid;
        mips_pkg::reg_addr_t rf_raddr1;
        mips_pkg::reg_addr_t rf_raddr2;
        mips_pkg::word_t     rf_rdata1;
        mips_pkg::word_t     rf_rdata2;
        mips_pkg::issue_t    id_issue;
        logic                id_issue_valid;
        mips_pkg::issue_t    ex_issue;
        logic                ex_issue_valid;
        mips_pkg::retire_t   ex_retire;
        logic                ex_retire_valid;
        logic                ex_fwd_wreg;
        mips_pkg::reg_addr_t ex_fwd_wd;
        mips_pkg::word_t     ex_fwd_wdata;
        mips_pkg::retire_t   wb_retire;
        logic                wb_retire_valid;
        logic                wb_wreg;

        fetch_unit fetch_unit_inst (
                .clk          (clk),
                .rst_n_i      (rst_n_i),
                .rom_data_i_le(rom_data_i_le),
                .rom_addr_o   (rom_addr_o),
                .rom_ce_o     (rom_ce_o),
                .inst_o       (if_inst),
                .inst_valid_o (if_inst_valid)
        );

        decode_stage decode_stage_inst (
                .inst_i       (if_inst),
                .inst_valid_i (if_inst_valid),
                .raddr1_o     (rf_raddr1),
                .raddr2_o     (rf_raddr2),
                .rdata1_i     (rf_rdata1),
                .rdata2_i     (rf_rdata2),
                .ex_wreg_i    (ex_fwd_wreg),
                .ex_wd_i      (ex_fwd_wd),
                .ex_wdata_i   (ex_fwd_wdata),
                .wb_wreg_i    (wb_wreg),
                .wb_wd_i      (wb_retire.wd),
                .wb_wdata_i   (wb_retire.result),
                .issue_o      (id_issue),
                .issue_valid_o(id_issue_valid)
        );

        reg_file reg_file_inst (
                .clk     (clk),
                .rst_n_i (rst_n_i),
                .we_i    (wb_wreg),
                .waddr_i (wb_retire.wd),
                .wdata_i (wb_retire.result),
                .raddr1_i(rf_raddr1),
                .raddr2_i(rf_raddr2),
                .rdata1_o(rf_rdata1),
                .rdata2_o(rf_rdata2)
        );

        stage_reg #(.payload_t(mips_pkg::issue_t)) issue_reg_inst (
                .clk    (clk),
                .rst_n_i(rst_n_i),
                .valid_i(id_issue_valid),
                .data_i (id_issue),
                .valid_o(ex_issue_valid),
                .data_o (ex_issue)
        );

        execute_stage execute_stage_inst (
                .issue_i       (ex_issue),
                .issue_valid_i (ex_issue_valid),
                .retire_o      (ex_retire),
                .retire_valid_o(ex_retire_valid),
                .fwd_wreg_o    (ex_fwd_wreg),
                .fwd_wd_o      (ex_fwd_wd),
                .fwd_wdata_o   (ex_fwd_wdata)
        );

        stage_reg #(.payload_t(mips_pkg::retire_t)) retire_reg_inst (
                .clk    (clk),
                .rst_n_i(rst_n_i),
                .valid_i(ex_retire_valid),
                .data_i (ex_retire),
                .valid_o(wb_retire_valid),
                .data_o (wb_retire)
        );

        // retire item drives both the register write and the store port
        assign wb_wreg    = wb_retire_valid & wb_retire.wreg;
        assign ram_we_o   = wb_retire_valid & wb_retire.store;
        assign ram_addr_o = wb_retire.result;
        assign ram_data_o = wb_retire.store_data;

endmodule

// File: logic/execute_stage.sv
// alu with store address add, retire item and forwarding outputs
`timescale 1ns/1ps

module execute_stage (
        input  mips_pkg::issue_t    issue_i,
        input  logic                issue_valid_i,
        output mips_pkg::retire_t   retire_o,
        output logic                retire_valid_o,
        output logic                fwd_wreg_o,
        output mips_pkg::reg_addr_t fwd_wd_o,
        output mips_pkg::word_t     fwd_wdata_o
);

        mips_pkg::word_t alu_result;

        // SW goes through ALU_ADD for its address
        always_comb begin
                case (issue_i.alu_op)
                        mips_pkg::ALU_ADD:    alu_result = issue_i.op_a + issue_i.op_b;
                        mips_pkg::ALU_SUB:    alu_result = issue_i.op_a - issue_i.op_b;
                        mips_pkg::ALU_AND:    alu_result = issue_i.op_a & issue_i.op_b;
                        mips_pkg::ALU_OR:     alu_result = issue_i.op_a | issue_i.op_b;
                        mips_pkg::ALU_XOR:    alu_result = issue_i.op_a ^ issue_i.op_b;
                        mips_pkg::ALU_NOR:    alu_result = ~(issue_i.op_a | issue_i.op_b);
                        mips_pkg::ALU_SLT: begin
                                alu_result = ($signed(issue_i.op_a) < $signed(issue_i.op_b))
                                             ? 32'd1 : 32'd0;
                        end
                        mips_pkg::ALU_PASS_B: alu_result = issue_i.op_b;
                        default:              alu_result = '0;
                endcase
        end

        always_comb begin
                retire_o.wreg       = issue_i.wreg;
                retire_o.wd         = issue_i.wd;
                retire_o.result     = alu_result;
                retire_o.store      = issue_i.store;
                retire_o.store_data = issue_i.store_data;
        end

        assign retire_valid_o = issue_valid_i;

        // newest result back to decode
        assign fwd_wreg_o  = issue_valid_i & issue_i.wreg;
        assign fwd_wd_o    = issue_i.wd;
        assign fwd_wdata_o = alu_result;

endmodule

// File: logic/stage_reg.sv
// pipeline register with valid bit for any payload type
`timescale 1ns/1ps

module stage_reg #(
        parameter type payload_t = logic
) (
        input  logic     clk,
        input  logic     rst_n_i,
        input  logic     valid_i,
        input  payload_t data_i,
        output logic     valid_o,
        output payload_t data_o
);

        logic     valid_q;
        payload_t data_q;

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        valid_q <= 1'b0;
                end else begin
                        valid_q <= valid_i;
                end
        end

        always_ff @(posedge clk) begin
                data_q <= data_i;
        end

        assign valid_o = valid_q;
        assign data_o  = data_q;

endmodule

// File: logic/decode_stage.sv
// instruction decode, immediate extension, operand forwarding and issue item
`timescale 1ns/1ps

module decode_stage (
        input  mips_pkg::word_t     inst_i,
        input  logic                inst_valid_i,
        output mips_pkg::reg_addr_t raddr1_o,
        output mips_pkg::reg_addr_t raddr2_o,
        input  mips_pkg::word_t     rdata1_i,
        input  mips_pkg::word_t     rdata2_i,
        input  logic                ex_wreg_i,
        input  mips_pkg::reg_addr_t ex_wd_i,
        input  mips_pkg::word_t     ex_wdata_i,
        input  logic                wb_wreg_i,
        input  mips_pkg::reg_addr_t wb_wd_i,
        input  mips_pkg::word_t     wb_wdata_i,
        output mips_pkg::issue_t    issue_o,
        output logic                issue_valid_o
);

        logic [5:0]          opcode;
        logic [5:0]          funct;
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t rd;
        logic [15:0]         imm;
        mips_pkg::word_t     imm_sext;
        mips_pkg::word_t     imm_zext;
        mips_pkg::word_t     imm_lui;
        mips_pkg::word_t     fwd_a;
        mips_pkg::word_t     fwd_b;

        // newest producer wins, $zero is never forwarded
        function automatic mips_pkg::word_t pick_operand(
                input mips_pkg::reg_addr_t addr,
                input mips_pkg::word_t     rf_data,
                input logic                ex_wreg,
                input mips_pkg::reg_addr_t ex_wd,
                input mips_pkg::word_t     ex_wdata,
                input logic                wb_wreg,
                input mips_pkg::reg_addr_t wb_wd,
                input mips_pkg::word_t     wb_wdata
        );
                if (addr == '0) begin
                        return rf_data;
                end else if (ex_wreg && (ex_wd == addr)) begin
                        return ex_wdata;
                end else if (wb_wreg && (wb_wd == addr)) begin
                        return wb_wdata;
                end
                return rf_data;
        endfunction

        assign opcode = inst_i[31:26];
        assign rs     = inst_i[25:21];
        assign rt     = inst_i[20:16];
        assign rd     = inst_i[15:11];
        assign funct  = inst_i[5:0];
        assign imm    = inst_i[15:0];

        assign imm_sext = {{16{imm[15]}}, imm};
        assign imm_zext = {16'h0000, imm};
        assign imm_lui  = {imm, 16'h0000};

        assign raddr1_o = rs;
        assign raddr2_o = rt;

        assign fwd_a = pick_operand(rs, rdata1_i, ex_wreg_i, ex_wd_i, ex_wdata_i,
                                    wb_wreg_i, wb_wd_i, wb_wdata_i);
        assign fwd_b = pick_operand(rt, rdata2_i, ex_wreg_i, ex_wd_i, ex_wdata_i,
                                    wb_wreg_i, wb_wd_i, wb_wdata_i);

        always_comb begin
                issue_o.alu_op     = mips_pkg::ALU_ADD;
                issue_o.op_a       = fwd_a;
                issue_o.op_b       = fwd_b;
                issue_o.wreg       = 1'b0;
                issue_o.wd         = rt;
                issue_o.store      = 1'b0;
                issue_o.store_data = fwd_b;
                case (opcode)
                        mips_pkg::OPC_SPECIAL: begin
                                issue_o.wd   = rd;
                                issue_o.wreg = 1'b1;
                                case (funct)
                                        mips_pkg::FN_ADDU: issue_o.alu_op = mips_pkg::ALU_ADD;
                                        mips_pkg::FN_SUBU: issue_o.alu_op = mips_pkg::ALU_SUB;
                                        mips_pkg::FN_AND:  issue_o.alu_op = mips_pkg::ALU_AND;
                                        mips_pkg::FN_OR:   issue_o.alu_op = mips_pkg::ALU_OR;
                                        mips_pkg::FN_XOR:  issue_o.alu_op = mips_pkg::ALU_XOR;
                                        mips_pkg::FN_NOR:  issue_o.alu_op = mips_pkg::ALU_NOR;
                                        mips_pkg::FN_SLT:  issue_o.alu_op = mips_pkg::ALU_SLT;
                                        default:           issue_o.wreg   = 1'b0;
                                endcase
                        end
                        mips_pkg::OPC_ADDIU: begin
                                issue_o.op_b = imm_sext;
                                issue_o.wreg = 1'b1;
                        end
                        mips_pkg::OPC_ANDI: begin
                                issue_o.alu_op = mips_pkg::ALU_AND;
                                issue_o.op_b   = imm_zext;
                                issue_o.wreg   = 1'b1;
                        end
                        mips_pkg::OPC_ORI: begin
                                issue_o.alu_op = mips_pkg::ALU_OR;
                                issue_o.op_b   = imm_zext;
                                issue_o.wreg   = 1'b1;
                        end
                        mips_pkg::OPC_XORI: begin
                                issue_o.alu_op = mips_pkg::ALU_XOR;
                                issue_o.op_b   = imm_zext;
                                issue_o.wreg   = 1'b1;
                        end
                        mips_pkg::OPC_LUI: begin
                                issue_o.alu_op = mips_pkg::ALU_PASS_B;
                                issue_o.op_b   = imm_lui;
                                issue_o.wreg   = 1'b1;
                        end
                        // address is rs plus offset, data comes from rt
                        mips_pkg::OPC_SW: begin
                                issue_o.op_b  = imm_sext;
                                issue_o.store = 1'b1;
                        end
                        default: begin
                                issue_o.wreg  = 1'b0;
                                issue_o.store = 1'b0;
                        end
                endcase
        end

        assign issue_valid_o = inst_valid_i;

endmodule

// File: logic/reg_file.sv
// general purpose register file, two combinational reads and one write
`timescale 1ns/1ps
`include "mips_config.svh"

module reg_file (
        input  logic                clk,
        input  logic                rst_n_i,
        input  logic                we_i,
        input  mips_pkg::reg_addr_t waddr_i,
        input  mips_pkg::word_t     wdata_i,
        input  mips_pkg::reg_addr_t raddr1_i,
        input  mips_pkg::reg_addr_t raddr2_i,
        output mips_pkg::word_t     rdata1_o,
        output mips_pkg::word_t     rdata2_o
);

        mips_pkg::word_t regs [`MIPS_REG_COUNT];

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we_i && (waddr_i != '0)) begin
                        regs[waddr_i] <= wdata_i;
                end
        end

        // $zero always reads as zero
        assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
        assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: logic/fetch_unit.sv
// program counter, rom enable, rom byte swap and fetch-to-decode register
`timescale 1ns/1ps
`include "mips_config.svh"

module fetch_unit (
        input  logic            clk,
        input  logic            rst_n_i,
        input  mips_pkg::word_t rom_data_i_le,
        output mips_pkg::word_t rom_addr_o,
        output logic            rom_ce_o,
        output mips_pkg::word_t inst_o,
        output logic            inst_valid_o
);

        mips_pkg::word_t pc_q;
        mips_pkg::word_t inst_be;
        logic            ce_q;
        logic            inst_valid_q;
        mips_pkg::word_t inst_q;

        // rom hands out little-endian words
        assign inst_be = {rom_data_i_le[7:0], rom_data_i_le[15:8],
                          rom_data_i_le[23:16], rom_data_i_le[31:24]};

        // pc only moves once the enable is up
        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        ce_q <= 1'b0;
                        pc_q <= `MIPS_RESET_PC;
                        inst_valid_q <= 1'b0;
                end else begin
                        ce_q <= 1'b1;
                        inst_valid_q <= ce_q;
                        if (ce_q) begin
                                pc_q <= pc_q + `MIPS_PC_STEP;
                        end
                end
        end

        always_ff @(posedge clk) begin
                inst_q <= inst_be;
        end

        assign rom_addr_o   = pc_q;
        assign rom_ce_o     = ce_q;
        assign inst_o       = inst_q;
        assign inst_valid_o = inst_valid_q;

endmodule

// File: logic/mips_pkg.sv
// word and register types, opcode, funct and alu enums, issue and retire structs
`include "mips_config.svh"

package mips_pkg;

        typedef logic [`MIPS_XLEN-1:0] word_t;
        typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

        // primary opcode field, inst[31:26]
        typedef enum logic [5:0] {
                OPC_SPECIAL = 6'b000000,
                OPC_ADDIU   = 6'b001001,
                OPC_ANDI    = 6'b001100,
                OPC_ORI     = 6'b001101,
                OPC_XORI    = 6'b001110,
                OPC_LUI     = 6'b001111,
                OPC_SW      = 6'b101011
        } opcode_e;

        // function field of SPECIAL, inst[5:0]
        typedef enum logic [5:0] {
                FN_ADDU = 6'b100001,
                FN_SUBU = 6'b100011,
                FN_AND  = 6'b100100,
                FN_OR   = 6'b100101,
                FN_XOR  = 6'b100110,
                FN_NOR  = 6'b100111,
                FN_SLT  = 6'b101010
        } funct_e;

        typedef enum logic [3:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_NOR,
                ALU_SLT,
                ALU_PASS_B
        } alu_op_e;

        typedef struct packed {
                alu_op_e   alu_op;
                word_t     op_a;
                word_t     op_b;
                logic      wreg;
                reg_addr_t wd;
                logic      store;
                word_t     store_data;
        } issue_t;

        // result doubles as the store address
        typedef struct packed {
                logic      wreg;
                reg_addr_t wd;
                word_t     result;
                logic      store;
                word_t     store_data;
        } retire_t;

endpackage

// File: logic/mips_config.svh
// core width, register file size, reset pc and fetch step macros
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// data and address word width
`define MIPS_XLEN 32

// register index width and register count
`define MIPS_REG_ADDR_W 5
`define MIPS_REG_COUNT 32

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// byte distance between consecutive fetches
`define MIPS_PC_STEP 32'd4

`endif
